//--- Makefile
# Verilator build and run of the colour tracker testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_vision, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_vision -Mdir obj_dir
	./obj_dir/Vtb_vision | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- classification.sv
`timescale 1ns/10ps

`include "vision_params.svh"

module classification
    import vision_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  pixel_t        cls_pix,
    input  logic          is_orange,
    output direction_t    direction,
    output logic          line_done,
    output frame_result_t result,
    output logic          frame_done
);

    // per-line zone counters
    logic [8:0]  cnt_left;
    logic [8:0]  cnt_center;
    logic [8:0]  cnt_right;
    // per-frame orange total, saturating
    logic [16:0] total;

    logic        count_en;
    logic        in_left;
    logic        in_right;
    logic [16:0] total_inc;
    direction_t  dir_next;

    // an orange pixel that counts this cycle
    assign count_en = cls_pix.valid & is_orange;

    // zone by column
    assign in_left  = (cls_pix.column < 9'(`ZONE_LEFT_END));
    assign in_right = (cls_pix.column >= 9'(`ZONE_RIGHT_START));

    // total including the current pixel, held at all ones
    always_comb begin
        total_inc = total;
        if (count_en && (total != '1)) begin
            total_inc = total + 17'd1;
        end
    end

    // direction from the final counts of the line
    always_comb begin
        dir_next = direction;
        if (cnt_right > cnt_left) begin
            dir_next = dir_right;
        end else if ((cnt_center > cnt_left) && (cnt_center > cnt_right)) begin
            dir_next = dir_center;
        end else if (cnt_left > cnt_right) begin
            dir_next = dir_left;
        end
        // a tie leaves the last direction in place
    end

    // line path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_left   <= '0;
            cnt_center <= '0;
            cnt_right  <= '0;
            direction  <= dir_none;
            line_done  <= 1'b0;
        end else begin
            line_done <= cls_pix.line_end;
            if (cls_pix.line_end) begin
                direction  <= dir_next;
                // fresh counts for the next line
                cnt_left   <= '0;
                cnt_center <= '0;
                cnt_right  <= '0;
            end else if (count_en) begin
                if (in_left) begin
                    cnt_left <= cnt_left + 9'd1;
                end else if (in_right) begin
                    cnt_right <= cnt_right + 9'd1;
                end else begin
                    cnt_center <= cnt_center + 9'd1;
                end
            end
        end
    end

    // frame path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            total      <= '0;
            result     <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= cls_pix.frame_end;
            if (cls_pix.frame_end) begin
                result.orange_count    <= {1'b0, total_inc};
                // strictly above the threshold
                result.orange_detected <= ({1'b0, total_inc} > 18'(`ORANGE_THRESHOLD));
                total                  <= '0;
            end else begin
                total <= total_inc;
            end
        end
    end

endmodule

//--- flist.f
+incdir+.
vision_pkg.sv
pixel_capture.sv
orange_classifier.sv
classification.sv
vision_top.sv
tb_vision.sv

//--- orange_classifier.sv
`timescale 1ns/10ps

`include "vision_params.svh"

module orange_classifier
    import vision_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  pixel_t cap_pix,
    output pixel_t cls_pix,
    output logic   is_orange
);

    rgb444_t colour;
    logic    hit;
    pixel_t  pix_q;

    // colour view of the incoming word
    assign colour = cap_pix.word.color.rgb;

    // window test, only meaningful on a valid pixel
    assign hit = cap_pix.valid
               && (colour.red >= `ORANGE_R_MIN)
               && (colour.green >= `ORANGE_G_MIN)
               && (colour.green <= `ORANGE_G_MAX)
               && (colour.blue <= `ORANGE_B_MAX);

    // verdict and pixel copy move together, one stage
    always_ff @(posedge clk) begin
        pix_q <= cap_pix;
        if (!rst_n) begin
            pix_q.valid     <= 1'b0;
            pix_q.line_end  <= 1'b0;
            pix_q.frame_end <= 1'b0;
            is_orange       <= 1'b0;
        end else begin
            is_orange <= hit;
        end
    end

    assign cls_pix = pix_q;

endmodule

//--- pixel_capture.sv
`timescale 1ns/10ps

`include "vision_params.svh"

module pixel_capture
    import vision_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic [7:0] cam_data,
    input  logic   href,
    input  logic   vsync,
    output pixel_t cap_pix
);

    // byte phase, high when the next byte completes a pixel
    logic       phase_q;
    // first byte of the pair, held until the second arrives
    logic [7:0] first_q;
    // column of the pixel being assembled
    logic [8:0] col_q;
    // previous sync levels for edge detection
    logic       href_q;
    logic       vsync_q;
    // registered pixel output
    pixel_t     cap_q;

    logic href_fall;
    logic vsync_rise;
    logic in_width;

    assign href_fall  = href_q & ~href;
    assign vsync_rise = vsync & ~vsync_q;
    // column stops at the width, so anything past it stays out
    assign in_width   = (col_q < 9'(`FRAME_WIDTH));

    always_ff @(posedge clk) begin
        // payload path
        if (href && !phase_q) begin
            first_q <= cam_data;
        end
        // joined word goes out through the raw view
        cap_q.word.raw <= {first_q, cam_data};
        cap_q.column   <= col_q;

        if (!rst_n) begin
            phase_q         <= 1'b0;
            col_q           <= '0;
            href_q          <= 1'b0;
            vsync_q         <= 1'b0;
            cap_q.valid     <= 1'b0;
            cap_q.line_end  <= 1'b0;
            cap_q.frame_end <= 1'b0;
        end else begin
            href_q  <= href;
            vsync_q <= vsync;

            // strobes, one cycle after the event
            cap_q.valid     <= href && phase_q && in_width;
            cap_q.line_end  <= href_fall;
            cap_q.frame_end <= vsync_rise;

            if (href) begin
                phase_q <= ~phase_q;
                // advance column on every completed pair within the line
                if (phase_q && in_width) begin
                    col_q <= col_q + 9'd1;
                end
            end else begin
                // blanking restarts pairing, odd trailing byte is lost
                phase_q <= 1'b0;
                col_q   <= '0;
            end
        end
    end

    assign cap_pix = cap_q;

endmodule

//--- tb_vision.sv
`timescale 1ns/10ps

`include "vision_params.svh"

module tb_vision
    import vision_pkg::*;
();

    logic          clk;
    logic          rst_n;
    logic [7:0]    cam_data;
    logic          href;
    logic          vsync;
    direction_t    direction;
    logic          line_done;
    frame_result_t result;
    logic          frame_done;

    // bookkeeping per test and for the whole run
    string cur_test;
    int    test_errors;
    int    test_checks;
    int    tests_passed;
    int    tests_failed;

    // orange share per zone in percent for the next line
    int pct_left;
    int pct_center;
    int pct_right;
    // zero or more selects an exact left/right tie of that many pixels
    int tie_k;
    // camera bytes of the line being sent
    logic [7:0] line_bytes[$];

    // reference model state
    direction_t model_dir;
    int         model_total;

    vision_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cam_data   (cam_data),
        .href       (href),
        .vsync      (vsync),
        .direction  (direction),
        .line_done  (line_done),
        .result     (result),
        .frame_done (frame_done)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // drive and sample point lies 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        test_checks++;
        assert (expected == actual) else begin
            $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s in test %s", msg, cur_test);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: passed, %0d checks", cur_test, test_checks);
            tests_passed++;
        end else begin
            $display("test %s: failed, %0d of %0d checks wrong", cur_test, test_errors,
                     test_checks);
            tests_failed++;
        end
    endtask

    // pixel inside the orange window with a random unused upper nibble
    function automatic logic [15:0] orange_pixel();
        logic [3:0] hi;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        hi = 4'($urandom);
        r  = 4'(10 + $urandom % 6);
        g  = 4'(3 + $urandom % 7);
        b  = 4'($urandom % 6);
        return {hi, r, g, b};
    endfunction

    // one component pushed just outside the window so this is never orange
    function automatic logic [15:0] background_pixel();
        logic [3:0] hi;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        hi = 4'($urandom);
        r  = 4'($urandom);
        g  = 4'($urandom);
        b  = 4'($urandom);
        case ($urandom % 3)
            0: r = 4'($urandom % 10);
            1: begin
                if ($urandom % 2 == 0)
                    g = 4'($urandom % 3);
                else
                    g = 4'(10 + $urandom % 6);
            end
            default: b = 4'(6 + $urandom % 10);
        endcase
        return {hi, r, g, b};
    endfunction

    function automatic int pick_pct();
        case ($urandom % 4)
            0: return 0;
            1: return 10;
            2: return 50;
            default: return 90;
        endcase
    endfunction

    // colour for a column by tie pattern or by zone share
    function automatic logic [15:0] pick_pixel(input int col);
        int pct;
        if (tie_k >= 0) begin
            if (col < tie_k || (col >= `ZONE_RIGHT_START && col < `ZONE_RIGHT_START + tie_k))
                return orange_pixel();
            return background_pixel();
        end
        if (col < `ZONE_LEFT_END)
            pct = pct_left;
        else if (col < `ZONE_RIGHT_START)
            pct = pct_center;
        else if (col < `FRAME_WIDTH)
            pct = pct_right;
        else
            pct = 50;
        if (int'($urandom % 100) < pct)
            return orange_pixel();
        return background_pixel();
    endfunction

    task automatic build_line(input int nbytes);
        logic [15:0] pix;
        line_bytes.delete();
        for (int i = 0; i < nbytes / 2; i++) begin
            pix = pick_pixel(i);
            line_bytes.push_back(pix[15:8]);
            line_bytes.push_back(pix[7:0]);
        end
        // odd trailing byte
        if (nbytes % 2 == 1)
            line_bytes.push_back(8'($urandom));
    endtask

    // pairs bytes, cuts at the width, counts zones, then applies the direction rule
    task automatic model_line();
        int         n_left;
        int         n_center;
        int         n_right;
        int         col;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        n_left   = 0;
        n_center = 0;
        n_right  = 0;
        col      = 0;
        for (int i = 0; i + 1 < line_bytes.size(); i += 2) begin
            // red sits in the low nibble of the first byte
            r = line_bytes[i][3:0];
            g = line_bytes[i + 1][7:4];
            b = line_bytes[i + 1][3:0];
            if (col < `FRAME_WIDTH && r >= `ORANGE_R_MIN && g >= `ORANGE_G_MIN
                && g <= `ORANGE_G_MAX && b <= `ORANGE_B_MAX) begin
                if (col < `ZONE_LEFT_END)
                    n_left++;
                else if (col >= `ZONE_RIGHT_START)
                    n_right++;
                else
                    n_center++;
                // frame total saturates at 17 bits
                if (model_total < 131071)
                    model_total++;
            end
            col++;
        end
        if (n_right > n_left)
            model_dir = dir_right;
        else if (n_center > n_left && n_center > n_right)
            model_dir = dir_center;
        else if (n_left > n_right)
            model_dir = dir_left;
    endtask

    // one line on the camera bus, then wait for line_done and check it
    task automatic send_line(input int nbytes);
        int   n;
        logic seen;
        build_line(nbytes);
        model_line();
        foreach (line_bytes[i]) begin
            cam_data = line_bytes[i];
            href     = 1'b1;
            next_cycle();
        end
        href     = 1'b0;
        cam_data = 8'($urandom);
        seen     = 1'b0;
        for (n = 0; n < 16 && !seen; n++) begin
            next_cycle();
            seen = line_done;
        end
        if (!seen)
            report_failure("timeout waiting for line_done");
        else
            check_value("direction", int'(model_dir), int'(direction));
        // a little extra blanking
        repeat ($urandom % 3) next_cycle();
    endtask

    // vsync pulse closes the frame and result is checked at frame_done
    task automatic close_frame(input int want_detected);
        int   n;
        logic seen;
        vsync = 1'b1;
        seen  = 1'b0;
        for (n = 0; n < 16 && !seen; n++) begin
            next_cycle();
            if (n == 1)
                vsync = 1'b0;
            seen = frame_done;
        end
        vsync = 1'b0;
        if (!seen) begin
            report_failure("timeout waiting for frame_done");
        end else begin
            check_value("orange_count", model_total, int'(result.orange_count));
            check_value("orange_detected", int'(model_total > `ORANGE_THRESHOLD),
                        int'(result.orange_detected));
            if (want_detected >= 0)
                check_value("detected for this mix", want_detected, int'(result.orange_detected));
        end
        model_total = 0;
    endtask

    task automatic random_mix();
        pct_left   = pick_pct();
        pct_center = pick_pct();
        pct_right  = pick_pct();
    endtask

    initial begin
        direction_t saved;
        int         nbytes;
        cam_data     = 8'd0;
        href         = 1'b0;
        vsync        = 1'b0;
        rst_n        = 1'b0;
        tie_k        = -1;
        pct_left     = 0;
        pct_center   = 0;
        pct_right    = 0;
        model_dir    = dir_none;
        model_total  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h131a_b576));

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset_idle");
        check_value("direction", int'(dir_none), int'(direction));
        check_value("orange_count", 0, int'(result.orange_count));
        check_value("orange_detected", 0, int'(result.orange_detected));
        repeat (20) begin
            cam_data = 8'($urandom);
            next_cycle();
            test_checks++;
            assert (!line_done && !frame_done) else
                report_failure("done pulse seen while href and vsync are low");
        end
        finish_test();

        start_test("zone_lines");
        repeat (40) begin
            random_mix();
            send_line(2 * `FRAME_WIDTH);
        end
        finish_test();

        // each tie line follows a normal one so the kept value varies
        start_test("tie_lines");
        repeat (20) begin
            random_mix();
            send_line(2 * `FRAME_WIDTH);
            saved = model_dir;
            tie_k = int'($urandom % 21);
            send_line(2 * `FRAME_WIDTH);
            tie_k = -1;
            check_value("direction kept on tie", int'(saved), int'(direction));
        end
        finish_test();

        // odd trailing bytes and lines past the frame width
        start_test("width_cut");
        repeat (30) begin
            random_mix();
            case ($urandom % 3)
                0: nbytes = 2 * (1 + int'($urandom % `FRAME_WIDTH)) + 1;
                1: nbytes = 2 * `FRAME_WIDTH + 1 + int'($urandom % 80);
                default: nbytes = 2 * (`FRAME_WIDTH + 1 + int'($urandom % 60));
            endcase
            send_line(nbytes);
        end
        finish_test();

        start_test("frame_count");
        close_frame(-1);
        finish_test();

        start_test("detect_high");
        pct_left   = 85;
        pct_center = 85;
        pct_right  = 85;
        repeat (`FRAME_HEIGHT) send_line(2 * `FRAME_WIDTH - 2 * int'($urandom % 4));
        close_frame(1);
        finish_test();

        start_test("detect_low");
        pct_left   = 3;
        pct_center = 3;
        pct_right  = 3;
        repeat (`FRAME_HEIGHT) send_line(2 * `FRAME_WIDTH - 2 * int'($urandom % 4));
        close_frame(0);
        finish_test();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vision_params.svh
`ifndef VISION_PARAMS_SVH
`define VISION_PARAMS_SVH

// frame geometry, in pixels and lines
`define FRAME_WIDTH 320
`define FRAME_HEIGHT 240

// zone bounds along a line
// left zone is columns below ZONE_LEFT_END
`define ZONE_LEFT_END 50
// right zone starts here, centre lies in between
`define ZONE_RIGHT_START 270

// frame counts as detected above a quarter of all pixels
`define ORANGE_THRESHOLD ((`FRAME_WIDTH * `FRAME_HEIGHT) / 4)

// orange colour window on rgb444 components
// strong red
`define ORANGE_R_MIN 4'd10
// moderate green, inclusive range
`define ORANGE_G_MIN 4'd3
`define ORANGE_G_MAX 4'd9
// little blue
`define ORANGE_B_MAX 4'd5

`endif

//--- vision_pkg.sv
package vision_pkg;

    // rgb444 colour as delivered by the camera
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // one pixel word, seen as raw bytes or as colour
    // raw view has the first camera byte in the upper half
    // colour view has four unused bits above the rgb444 value
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [3:0] pad;
            rgb444_t    rgb;
        } color;
    } pixel_word_u;

    // pixel plus its line and frame strobes
    typedef struct packed {
        logic        valid;
        pixel_word_u word;
        logic [8:0]  column;
        logic        line_end;
        logic        frame_end;
    } pixel_t;

    // steering direction reported per line
    typedef enum logic [2:0] {
        dir_none   = 3'd0,
        dir_left   = 3'd1,
        dir_right  = 3'd2,
        dir_center = 3'd3
    } direction_t;

    // per-frame outcome
    typedef struct packed {
        logic [17:0] orange_count;
        logic        orange_detected;
    } frame_result_t;

endpackage

//--- vision_top.sv
`timescale 1ns/10ps

module vision_top
    import vision_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic [7:0]    cam_data,
    input  logic          href,
    input  logic          vsync,
    output direction_t    direction,
    output logic          line_done,
    output frame_result_t result,
    output logic          frame_done
);

    // capture to classifier
    pixel_t cap_pix;
    // classifier to classification, with its verdict
    pixel_t cls_pix;
    logic   is_orange;

    // byte pairing, column and sync strobes
    pixel_capture u_capture (
        .clk      (clk),
        .rst_n    (rst_n),
        .cam_data (cam_data),
        .href     (href),
        .vsync    (vsync),
        .cap_pix  (cap_pix)
    );

    // colour window test
    orange_classifier u_classifier (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_pix   (cap_pix),
        .cls_pix   (cls_pix),
        .is_orange (is_orange)
    );

    // zone counts and frame totals
    classification u_classification (
        .clk        (clk),
        .rst_n      (rst_n),
        .cls_pix    (cls_pix),
        .is_orange  (is_orange),
        .direction  (direction),
        .line_done  (line_done),
        .result     (result),
        .frame_done (frame_done)
    );

endmodule
